// ==== verilog.f ====
logic/fsab_pkg.sv
logic/mem_pkg.sv
logic/fsab_traffic_gen.sv
logic/fsab_mem_frontend.sv
logic/fsab_mem_bank.sv
logic/fsab_read_return.sv
logic/fsab_test_system.sv
testbench/tb_fsab_test_system.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Verilator build and run of the FSAB memory testbench
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module tb_fsab_test_system -Mdir obj_dir > build.log 2>&1 \
	&& ./obj_dir/Vtb_fsab_test_system > sim.log 2>&1 \
	|| { echo "Build or simulation error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "TEST FAIL" sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "No pass result found in sim.log"; exit 1; }
exit 0

// ==== testbench/tb_fsab_test_system.sv ====
`timescale 1ns/1ns

module tb_fsab_test_system;

	logic fclk;
	logic fclk_rst_b;
	logic corerst_btn;
	logic fsabi_valid;
	logic [fsab_pkg::FSAB_DID_W-1:0] fsabi_did;
	logic [fsab_pkg::FSAB_DID_W-1:0] fsabi_subdid;
	logic [fsab_pkg::FSAB_DATA_W-1:0] fsabi_data;
	logic tb_done;

	int seed;		// $random state
	int err_cnt;		// Failed checks, all tests
	int tests_run;
	int tests_failed;
	int run_num;		// Which of the two runs is going on
	int beat_cnt;		// fsabi beats seen since reset
	int burst_err_start;	// err_cnt when the current burst began
	bit pre_btn;		// Reset done, button not pressed yet
	bit prev_valid;		// fsabi_valid in the previous cycle
	bit done_seen;		// tb_done has risen since reset
	bit timed_out;
	logic [63:0] exp_word;

	fsab_test_system DUT (
		.fclk(fclk),
		.fclk_rst_b(fclk_rst_b),
		.corerst_btn(corerst_btn),
		.fsabi_valid(fsabi_valid),
		.fsabi_did(fsabi_did),
		.fsabi_subdid(fsabi_subdid),
		.fsabi_data(fsabi_data),
		.tb_done(tb_done)
	);

	always #10 fclk = ~fclk;	// 20 ns period

	// Byte model of the script's writes
	// Burst n sees the first n+1 writes
	function automatic logic [63:0] expected_word(input int burst, input int idx);
		logic [7:0] bytes [64];
		fsab_pkg::fsab_word_t w;
		logic [3:0] nib;
		logic [7:0] mask;
		for (int b = 0; b < 8; b++) begin	// Ramp write, full mask
			nib = 4'(8 - b);
			w.word = {16{nib}};
			for (int k = 0; k < 8; k++)
				bytes[b * 8 + k] = w.lanes[k];
		end
		if (burst >= 1) begin	// Word 2, upper lanes
			w.word = 64'h1EA754171EA75417;
			mask = 8'hF0;
			for (int k = 0; k < 8; k++)
				if (mask[k])
					bytes[16 + k] = w.lanes[k];
		end
		if (burst >= 2) begin	// Word 1, lower lanes
			w.word = 64'h1337133713371337;
			mask = 8'h0F;
			for (int k = 0; k < 8; k++)
				if (mask[k])
					bytes[8 + k] = w.lanes[k];
		end
		for (int k = 0; k < 8; k++)
			w.lanes[k] = bytes[idx * 8 + k];
		return w.word;
	endfunction

	// One result line per finished test
	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (err_cnt > errs_before) begin
			tests_failed++;
			$display("%s: failed, %0d errors", name, err_cnt - errs_before);
		end else begin
			$display("%s: ok", name);
		end
	endtask

	// Response checker sampled mid-cycle
	always @(negedge fclk) begin
		if (!fclk_rst_b) begin
			beat_cnt = 0;
			prev_valid = 1'b0;
			done_seen = 1'b0;
		end else begin
			if (pre_btn)
				assert (!fsabi_valid && !tb_done) else begin
					$display("Fail at %0t: activity before button, valid %b done %b",
						$time, fsabi_valid, tb_done);
					err_cnt++;
				end
			if (done_seen)
				assert (tb_done) else begin
					$display("Fail at %0t: tb_done dropped before reset", $time);
					err_cnt++;
				end
			if (tb_done)
				done_seen = 1'b1;
			if (fsabi_valid) begin
				if (beat_cnt % 8 == 0)
					burst_err_start = err_cnt;
				assert (beat_cnt < 24) else begin
					$display("Fail at %0t: extra read beat %0d", $time, beat_cnt);
					err_cnt++;
				end
				exp_word = expected_word(beat_cnt / 8, beat_cnt % 8);
				assert (fsabi_data === exp_word) else begin
					$display("Fail at %0t: burst %0d word %0d data %h, expected %h", $time,
						beat_cnt / 8, beat_cnt % 8, fsabi_data, exp_word);
					err_cnt++;
				end
				assert (fsabi_did === 4'd0 && fsabi_subdid === 4'd0) else begin
					$display("Fail at %0t: DID %h subDID %h, expected 0 and 0", $time,
						fsabi_did, fsabi_subdid);
					err_cnt++;
				end
				if (beat_cnt % 8 != 0)	// Burst beats back to back
					assert (prev_valid) else begin
						$display("Fail at %0t: gap before word %0d of burst %0d", $time,
							beat_cnt % 8, beat_cnt / 8);
						err_cnt++;
					end
				if (beat_cnt % 8 == 7)
					report_test($sformatf("run %0d read burst %0d", run_num, beat_cnt / 8),
						burst_err_start);
				beat_cnt++;
			end
			prev_valid = fsabi_valid;
		end
	end

	// Reset, idle check, button press, then wait for the script to finish
	task automatic run_script(input int r);
		int start;
		int cycles;
		int idle_cycles;
		int press_cycles;
		run_num = r;
		@(posedge fclk);
		fclk_rst_b <= 1'b0;
		corerst_btn <= 1'b0;
		pre_btn = 1'b1;
		repeat (16) @(posedge fclk);
		fclk_rst_b <= 1'b1;
		start = err_cnt;
		idle_cycles = 8 + ({$random(seed)} % 24);
		repeat (idle_cycles) @(posedge fclk);
		report_test($sformatf("run %0d idle before button", r), start);
		press_cycles = 4 + ({$random(seed)} % 7);	// 4 to 10 cycles
		corerst_btn <= 1'b1;
		pre_btn = 1'b0;
		repeat (press_cycles) @(posedge fclk);
		corerst_btn <= 1'b0;
		start = err_cnt;
		cycles = 0;
		while (!tb_done && cycles < 400) begin
			@(negedge fclk);
			cycles++;
		end
		if (!tb_done) begin
			$display("Timeout: tb_done did not rise within 400 cycles in run %0d", r);
			err_cnt++;
			timed_out = 1'b1;
		end else begin
			cycles = 0;
			while (beat_cnt < 24 && cycles < 50) begin	// Last beats trail tb_done
				@(posedge fclk);
				cycles++;
			end
			if (beat_cnt < 24) begin
				$display("Timeout: only %0d read beats arrived in run %0d", beat_cnt, r);
				err_cnt++;
				timed_out = 1'b1;
			end else begin
				repeat (10) @(posedge fclk);	// Window for stray beats
				@(negedge fclk);
				assert (beat_cnt == 24 && tb_done) else begin
					$display("Fail at %0t: %0d beats after done, tb_done %b", $time,
						beat_cnt, tb_done);
					err_cnt++;
				end
			end
		end
		report_test($sformatf("run %0d done after 24 beats", r), start);
	endtask

	initial begin
		fclk = 1'b0;
		fclk_rst_b = 1'b0;
		corerst_btn = 1'b0;
		seed = 32'ha1da;
		err_cnt = 0;
		tests_run = 0;
		tests_failed = 0;
		run_num = 0;
		burst_err_start = 0;
		pre_btn = 1'b1;
		timed_out = 1'b0;
		for (int r = 0; r < 2; r++)	// Second run after a full reset
			if (!timed_out)
				run_script(r);
		$display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed,
			err_cnt);
		if (err_cnt == 0 && tests_failed == 0 && !timed_out)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== logic/fsab_test_system.sv ====
`timescale 1ns/1ns

module fsab_test_system (
	input logic fclk,
	input logic fclk_rst_b,
	input logic corerst_btn,
	output logic fsabi_valid,
	output logic [fsab_pkg::FSAB_DID_W-1:0] fsabi_did,
	output logic [fsab_pkg::FSAB_DID_W-1:0] fsabi_subdid,
	output logic [fsab_pkg::FSAB_DATA_W-1:0] fsabi_data,
	output logic tb_done
);

	// Request channel
	logic fsabo_valid;
	logic [fsab_pkg::FSAB_REQ_W-1:0] fsabo_mode;
	logic [fsab_pkg::FSAB_DID_W-1:0] fsabo_did;
	logic [fsab_pkg::FSAB_DID_W-1:0] fsabo_subdid;
	logic [fsab_pkg::FSAB_ADDR_W-1:0] fsabo_addr;
	logic [fsab_pkg::FSAB_LEN_W-1:0] fsabo_len;
	logic [fsab_pkg::FSAB_DATA_W-1:0] fsabo_data;
	logic [fsab_pkg::FSAB_MASK_W-1:0] fsabo_mask;
	logic fsabo_credit;

	// Bank ports
	logic bank0_wr_en;
	logic bank0_rd_en;
	logic [mem_pkg::BANK_ROW_W-1:0] bank0_row;
	logic [fsab_pkg::FSAB_DATA_W-1:0] bank0_wdata;
	logic [fsab_pkg::FSAB_MASK_W-1:0] bank0_mask;
	logic [fsab_pkg::FSAB_DATA_W-1:0] bank0_rdata;
	logic bank1_wr_en;
	logic bank1_rd_en;
	logic [mem_pkg::BANK_ROW_W-1:0] bank1_row;
	logic [fsab_pkg::FSAB_DATA_W-1:0] bank1_wdata;
	logic [fsab_pkg::FSAB_MASK_W-1:0] bank1_mask;
	logic [fsab_pkg::FSAB_DATA_W-1:0] bank1_rdata;

	// Read tag, one cycle behind the bank read
	logic rd_pend;
	logic rd_sel;
	logic [fsab_pkg::FSAB_DID_W-1:0] rd_did;
	logic [fsab_pkg::FSAB_DID_W-1:0] rd_subdid;

	fsab_traffic_gen gen (
		.fclk(fclk),
		.fclk_rst_b(fclk_rst_b),
		.corerst_btn(corerst_btn),
		.fsabo_credit(fsabo_credit),
		.fsabo_valid(fsabo_valid),
		.fsabo_mode(fsabo_mode),
		.fsabo_did(fsabo_did),
		.fsabo_subdid(fsabo_subdid),
		.fsabo_addr(fsabo_addr),
		.fsabo_len(fsabo_len),
		.fsabo_data(fsabo_data),
		.fsabo_mask(fsabo_mask),
		.tb_done(tb_done)
	);

	fsab_mem_frontend fe (
		.fclk(fclk),
		.fclk_rst_b(fclk_rst_b),
		.fsabo_valid(fsabo_valid),
		.fsabo_mode(fsabo_mode),
		.fsabo_did(fsabo_did),
		.fsabo_subdid(fsabo_subdid),
		.fsabo_addr(fsabo_addr),
		.fsabo_len(fsabo_len),
		.fsabo_data(fsabo_data),
		.fsabo_mask(fsabo_mask),
		.fsabo_credit(fsabo_credit),
		.bank0_wr_en(bank0_wr_en),
		.bank0_rd_en(bank0_rd_en),
		.bank0_row(bank0_row),
		.bank0_wdata(bank0_wdata),
		.bank0_mask(bank0_mask),
		.bank1_wr_en(bank1_wr_en),
		.bank1_rd_en(bank1_rd_en),
		.bank1_row(bank1_row),
		.bank1_wdata(bank1_wdata),
		.bank1_mask(bank1_mask),
		.rd_pend(rd_pend),
		.rd_sel(rd_sel),
		.rd_did(rd_did),
		.rd_subdid(rd_subdid)
	);

	fsab_mem_bank bank0 (		// Even words
		.fclk(fclk),
		.wr_en(bank0_wr_en),
		.rd_en(bank0_rd_en),
		.row(bank0_row),
		.wdata(bank0_wdata),
		.mask(bank0_mask),
		.rdata(bank0_rdata)
	);

	fsab_mem_bank bank1 (		// Odd words
		.fclk(fclk),
		.wr_en(bank1_wr_en),
		.rd_en(bank1_rd_en),
		.row(bank1_row),
		.wdata(bank1_wdata),
		.mask(bank1_mask),
		.rdata(bank1_rdata)
	);

	fsab_read_return rret (
		.fclk(fclk),
		.fclk_rst_b(fclk_rst_b),
		.bank0_rdata(bank0_rdata),
		.bank1_rdata(bank1_rdata),
		.rd_pend(rd_pend),
		.rd_sel(rd_sel),
		.rd_did(rd_did),
		.rd_subdid(rd_subdid),
		.fsabi_valid(fsabi_valid),
		.fsabi_did(fsabi_did),
		.fsabi_subdid(fsabi_subdid),
		.fsabi_data(fsabi_data)
	);

endmodule

// ==== logic/fsab_read_return.sv ====
`timescale 1ns/1ns

module fsab_read_return (
	input logic fclk,
	input logic fclk_rst_b,
	input logic [fsab_pkg::FSAB_DATA_W-1:0] bank0_rdata,
	input logic [fsab_pkg::FSAB_DATA_W-1:0] bank1_rdata,
	input logic rd_pend,
	input logic rd_sel,
	input logic [fsab_pkg::FSAB_DID_W-1:0] rd_did,
	input logic [fsab_pkg::FSAB_DID_W-1:0] rd_subdid,
	output logic fsabi_valid,
	output logic [fsab_pkg::FSAB_DID_W-1:0] fsabi_did,
	output logic [fsab_pkg::FSAB_DID_W-1:0] fsabi_subdid,
	output logic [fsab_pkg::FSAB_DATA_W-1:0] fsabi_data
);

	logic [fsab_pkg::FSAB_DATA_W-1:0] ret_word;	// Word from the bank just read

	// Only one bank reads per cycle, so a plain mux keeps order
	assign ret_word = rd_sel ? bank1_rdata : bank0_rdata;

	always_ff @(posedge fclk or negedge fclk_rst_b) begin
		if (!fclk_rst_b)
			fsabi_valid <= 1'b0;
		else
			fsabi_valid <= rd_pend;	// No stall on fsabi
	end

	// Beat payload, holds between bursts
	always_ff @(posedge fclk) begin
		if (rd_pend) begin
			fsabi_data <= ret_word;
			fsabi_did <= rd_did;	// Carried through from the request
			fsabi_subdid <= rd_subdid;
		end
	end

endmodule

// ==== logic/fsab_mem_bank.sv ====
`timescale 1ns/1ns

module fsab_mem_bank (
	input logic fclk,
	input logic wr_en,
	input logic rd_en,
	input logic [mem_pkg::BANK_ROW_W-1:0] row,
	input logic [fsab_pkg::FSAB_DATA_W-1:0] wdata,
	input logic [fsab_pkg::FSAB_MASK_W-1:0] mask,
	output logic [fsab_pkg::FSAB_DATA_W-1:0] rdata
);

	fsab_pkg::fsab_word_t mem [mem_pkg::MEM_WORDS_PER_BANK];	// Word array
	fsab_pkg::fsab_word_t wword;	// Write data seen as byte lanes

	assign wword = wdata;

	// Masked write, lanes with a clear mask bit keep their old byte
	always_ff @(posedge fclk) begin
		if (wr_en) begin
			for (int k = 0; k < fsab_pkg::FSAB_MASK_W; k++) begin
				if (mask[k])
					mem[row].lanes[k] <= wword.lanes[k];
			end
		end
	end

	// Registered read, data one cycle after rd_en
	always_ff @(posedge fclk) begin
		if (rd_en)
			rdata <= mem[row].word;
	end

endmodule

// ==== logic/fsab_mem_frontend.sv ====
`timescale 1ns/1ns

module fsab_mem_frontend (
	input logic fclk,
	input logic fclk_rst_b,
	input logic fsabo_valid,
	input logic [fsab_pkg::FSAB_REQ_W-1:0] fsabo_mode,
	input logic [fsab_pkg::FSAB_DID_W-1:0] fsabo_did,
	input logic [fsab_pkg::FSAB_DID_W-1:0] fsabo_subdid,
	input logic [fsab_pkg::FSAB_ADDR_W-1:0] fsabo_addr,
	input logic [fsab_pkg::FSAB_LEN_W-1:0] fsabo_len,
	input logic [fsab_pkg::FSAB_DATA_W-1:0] fsabo_data,
	input logic [fsab_pkg::FSAB_MASK_W-1:0] fsabo_mask,
	output logic fsabo_credit,
	output logic bank0_wr_en,
	output logic bank0_rd_en,
	output logic [mem_pkg::BANK_ROW_W-1:0] bank0_row,
	output logic [fsab_pkg::FSAB_DATA_W-1:0] bank0_wdata,
	output logic [fsab_pkg::FSAB_MASK_W-1:0] bank0_mask,
	output logic bank1_wr_en,
	output logic bank1_rd_en,
	output logic [mem_pkg::BANK_ROW_W-1:0] bank1_row,
	output logic [fsab_pkg::FSAB_DATA_W-1:0] bank1_wdata,
	output logic [fsab_pkg::FSAB_MASK_W-1:0] bank1_mask,
	output logic rd_pend,
	output logic rd_sel,
	output logic [fsab_pkg::FSAB_DID_W-1:0] rd_did,
	output logic [fsab_pkg::FSAB_DID_W-1:0] rd_subdid
);

	// Beat queue, extra pointer bit tells full from empty
	logic [fsab_pkg::FSAB_BEAT_W-1:0] fifo_mem [mem_pkg::REQ_FIFO_DEPTH];
	logic [mem_pkg::REQ_FIFO_AW:0] wr_ptr;
	logic [mem_pkg::REQ_FIFO_AW:0] rd_ptr;
	logic fifo_empty;
	logic fifo_full;
	logic push;
	logic pop;

	// Head of queue, unpacked
	logic [fsab_pkg::FSAB_REQ_W-1:0] h_mode;
	logic [fsab_pkg::FSAB_DID_W-1:0] h_did;
	logic [fsab_pkg::FSAB_DID_W-1:0] h_subdid;
	logic [fsab_pkg::FSAB_ADDR_W-1:0] h_addr;
	logic [fsab_pkg::FSAB_LEN_W-1:0] h_len;
	logic [fsab_pkg::FSAB_DATA_W-1:0] h_data;
	logic [fsab_pkg::FSAB_MASK_W-1:0] h_mask;

	logic [fsab_pkg::FSAB_LEN_W-1:0] beat_cnt;	// Word within current burst
	logic [mem_pkg::MEM_WORD_IDX_W-1:0] word_idx;
	logic bank_sel;
	logic head_rd;
	logic head_wr;
	logic head_last;

	assign fifo_empty = (wr_ptr == rd_ptr);
	assign fifo_full = (wr_ptr == {~rd_ptr[mem_pkg::REQ_FIFO_AW],
		rd_ptr[mem_pkg::REQ_FIFO_AW-1:0]});
	assign push = fsabo_valid && !fifo_full;	// Credit scheme keeps this from filling

	always_ff @(posedge fclk) begin
		if (push)
			fifo_mem[wr_ptr[mem_pkg::REQ_FIFO_AW-1:0]] <= {fsabo_mode, fsabo_did,
				fsabo_subdid, fsabo_addr, fsabo_len, fsabo_data, fsabo_mask};
	end

	assign {h_mode, h_did, h_subdid, h_addr, h_len, h_data, h_mask} =
		fifo_mem[rd_ptr[mem_pkg::REQ_FIFO_AW-1:0]];

	// Anything not a read is treated as a write beat
	assign head_rd = !fifo_empty && (h_mode == fsab_pkg::FSAB_READ);
	assign head_wr = !fifo_empty && (h_mode != fsab_pkg::FSAB_READ);
	assign head_last = (beat_cnt == h_len - 1'b1);

	// Writes leave one beat per cycle, a read beat stays until all words issued
	assign pop = head_wr || (head_rd && head_last);
	assign fsabo_credit = !fifo_empty && head_last;

	always_ff @(posedge fclk or negedge fclk_rst_b) begin
		if (!fclk_rst_b) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			beat_cnt <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (!fifo_empty)
				beat_cnt <= head_last ? '0 : beat_cnt + 1'b1;
		end
	end

	// Byte address to word index, then step through the burst
	assign word_idx = h_addr[3 +: mem_pkg::MEM_WORD_IDX_W] +
		{{(mem_pkg::MEM_WORD_IDX_W - fsab_pkg::FSAB_LEN_W){1'b0}}, beat_cnt};
	assign bank_sel = word_idx[0];	// Odd words live in bank 1

	assign bank0_wr_en = head_wr && !bank_sel;
	assign bank0_rd_en = head_rd && !bank_sel;
	assign bank0_row = word_idx[mem_pkg::MEM_WORD_IDX_W-1:1];
	assign bank0_wdata = h_data;
	assign bank0_mask = h_mask;

	assign bank1_wr_en = head_wr && bank_sel;
	assign bank1_rd_en = head_rd && bank_sel;
	assign bank1_row = word_idx[mem_pkg::MEM_WORD_IDX_W-1:1];
	assign bank1_wdata = h_data;
	assign bank1_mask = h_mask;

	// Tag follows the bank read by one cycle
	always_ff @(posedge fclk or negedge fclk_rst_b) begin
		if (!fclk_rst_b) begin
			rd_pend <= 1'b0;
			rd_sel <= 1'b0;
		end else begin
			rd_pend <= head_rd;
			rd_sel <= bank_sel;
		end
	end

	always_ff @(posedge fclk) begin
		if (head_rd) begin
			rd_did <= h_did;
			rd_subdid <= h_subdid;
		end
	end

endmodule

// ==== logic/fsab_traffic_gen.sv ====
`timescale 1ns/1ns

module fsab_traffic_gen (
	input logic fclk,
	input logic fclk_rst_b,
	input logic corerst_btn,
	input logic fsabo_credit,
	output logic fsabo_valid,
	output logic [fsab_pkg::FSAB_REQ_W-1:0] fsabo_mode,
	output logic [fsab_pkg::FSAB_DID_W-1:0] fsabo_did,
	output logic [fsab_pkg::FSAB_DID_W-1:0] fsabo_subdid,
	output logic [fsab_pkg::FSAB_ADDR_W-1:0] fsabo_addr,
	output logic [fsab_pkg::FSAB_LEN_W-1:0] fsabo_len,
	output logic [fsab_pkg::FSAB_DATA_W-1:0] fsabo_data,
	output logic [fsab_pkg::FSAB_MASK_W-1:0] fsabo_mask,
	output logic tb_done
);

	logic [3:0] cr_btn;		// Button synchronizer, bit 3 is safe to use
	logic [1:0] phase;		// 0 idle, 1 send, 2 wait credit, 3 done
	logic [2:0] step;		// Script entry, 0 to 5
	logic [fsab_pkg::FSAB_LEN_W-1:0] beat_cnt;	// Beats sent in this request
	logic [fsab_pkg::FSAB_LEN_W-1:0] beats_left;	// Ramp data for the first write
	logic last_beat;

	// Button comes from a pad, four flops before it is used
	always_ff @(posedge fclk or negedge fclk_rst_b) begin
		if (!fclk_rst_b)
			cr_btn <= '0;
		else
			cr_btn <= {cr_btn[2:0], corerst_btn};
	end

	assign beats_left = mem_pkg::MEM_BURST_MAX - beat_cnt;

	// Request contents per script entry
	always_comb begin
		fsabo_mode = fsab_pkg::FSAB_READ;	// Default is 8-word read of 0x0
		fsabo_did = fsab_pkg::TG_DID;
		fsabo_subdid = fsab_pkg::TG_SUBDID;
		fsabo_addr = '0;
		fsabo_len = mem_pkg::MEM_BURST_MAX;
		fsabo_data = '0;			// Unused on reads
		fsabo_mask = 8'hFF;
		case (step)
		3'd0: begin	// 8-word write to 0x0, each nibble is the beats left
			fsabo_mode = fsab_pkg::FSAB_WRITE;
			fsabo_data = {16{beats_left}};
		end
		3'd2: begin	// 1-word write to 0x10, upper half only
			fsabo_mode = fsab_pkg::FSAB_WRITE;
			fsabo_addr = 31'h10;
			fsabo_len = 4'd1;
			fsabo_data = 64'h1EA754171EA75417;
			fsabo_mask = 8'hF0;
		end
		3'd4: begin	// 1-word write to 0x8, lower half only
			fsabo_mode = fsab_pkg::FSAB_WRITE;
			fsabo_addr = 31'h8;
			fsabo_len = 4'd1;
			fsabo_data = 64'h1337133713371337;
			fsabo_mask = 8'h0F;
		end
		default: begin
		end
		endcase
	end

	// A read is one beat whatever its length
	assign last_beat = (fsabo_mode == fsab_pkg::FSAB_READ) ||
		(beat_cnt == fsabo_len - 1'b1);

	assign fsabo_valid = (phase == 2'd1);
	assign tb_done = (phase == 2'd3);

	always_ff @(posedge fclk or negedge fclk_rst_b) begin
		if (!fclk_rst_b) begin
			phase <= 2'd0;
			step <= '0;
			beat_cnt <= '0;
		end else begin
			case (phase)
			2'd0: begin
				if (cr_btn[3])
					phase <= 2'd1;
			end
			2'd1: begin	// One beat per cycle, no stall on the request side
				if (last_beat) begin
					beat_cnt <= '0;
					phase <= 2'd2;
				end else begin
					beat_cnt <= beat_cnt + 1'b1;
				end
			end
			2'd2: begin	// Hold off until the front end takes the request
				if (fsabo_credit) begin
					if (step == 3'd5) begin
						phase <= 2'd3;
					end else begin
						step <= step + 1'b1;
						phase <= 2'd1;
					end
				end
			end
			default: begin	// Done until the next reset
			end
			endcase
		end
	end

endmodule

// ==== logic/mem_pkg.sv ====
package mem_pkg;

	// Two banks, word interleaved on word index bit 0
	localparam int MEM_BANKS = 2;
	localparam int MEM_WORDS_PER_BANK = 64;
	localparam int BANK_ROW_W = 6;		// log2 of words per bank

	// Full word index, row bits above the bank select
	localparam int MEM_WORD_IDX_W = BANK_ROW_W + $clog2(MEM_BANKS);

	// Request beat queue
	localparam int REQ_FIFO_DEPTH = 16;
	localparam int REQ_FIFO_AW = $clog2(REQ_FIFO_DEPTH);

	// Longest burst, sized like the FSAB length field
	localparam logic [3:0] MEM_BURST_MAX = 4'd8;

endpackage

// ==== logic/fsab_pkg.sv ====
package fsab_pkg;

	// Request and response channel widths
	localparam int FSAB_ADDR_W = 31;	// Byte address
	localparam int FSAB_DATA_W = 64;	// One word per beat
	localparam int FSAB_MASK_W = 8;		// One bit per byte lane
	localparam int FSAB_LEN_W  = 4;		// 1 to 8 beats
	localparam int FSAB_DID_W  = 4;		// DID and subDID alike
	localparam int FSAB_REQ_W  = 2;		// Mode field

	// Request modes
	localparam logic [FSAB_REQ_W-1:0] FSAB_READ  = 2'd0;
	localparam logic [FSAB_REQ_W-1:0] FSAB_WRITE = 2'd1;

	// One queued request beat, all header fields plus payload
	localparam int FSAB_BEAT_W = FSAB_REQ_W + 2 * FSAB_DID_W + FSAB_ADDR_W +
		FSAB_LEN_W + FSAB_DATA_W + FSAB_MASK_W;

	// Data word, whole or split into byte lanes
	// Lane k is bits 8k+7 down to 8k, matching mask bit k
	typedef union packed {
		logic [FSAB_DATA_W-1:0] word;
		logic [FSAB_MASK_W-1:0][7:0] lanes;
	} fsab_word_t;

	// Traffic generator identifiers
	localparam logic [FSAB_DID_W-1:0] TG_DID    = 4'd0;
	localparam logic [FSAB_DID_W-1:0] TG_SUBDID = 4'd0;

endpackage
